/* files.f */
source/forthIsaPkg.sv
source/forthCtrlPkg.sv
source/instructionPhaseDecoder.sv
source/aluGroupDecoder.sv
source/registerFile.sv
source/aluDatapath.sv
source/forthAluCore.sv
sim/forthAluCore_chk.sv
sim/forthAluCoreTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the forthAluCore testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module forthAluCoreTb -Mdir obj_dir -f files.f

# keep running after an assertion error so the testbench can report it
./obj_dir/VforthAluCoreTb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* sim/forthAluCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module forthAluCoreTb
	import forthIsaPkg::*;
();

	localparam int TIMEOUT_CYCLES = 20;

	logic      CLK = 1'b0;
	logic      reset;
	word_t     instruction;
	logic      fetch;
	logic      writeValid;
	regIndex_t writeReg;
	word_t     writeData;
	logic      zeroFlag;
	logic      carryFlag;

	word_t model [16]; // expected register contents
	int    errors = 0;
	int    testErrors;
	int    testsRun = 0;
	int    testsFailed = 0;

	forthAluCore dut_i (
		.CLK         (CLK),
		.reset       (reset),
		.instruction (instruction),
		.fetch       (fetch),
		.writeValid  (writeValid),
		.writeReg    (writeReg),
		.writeData   (writeData),
		.zeroFlag    (zeroFlag),
		.carryFlag   (carryFlag)
	);

	always #4 CLK = ~CLK;

	task automatic finishRun();
		$display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
			testsRun, testsFailed, errors, dut_i.chk_i.failCount);
		if (errors == 0 && dut_i.chk_i.failCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	// called on a falling edge, returns the number of edges waited
	task automatic waitForFetch(output int cycles);
		int n = 0;
		while (!fetch && n < TIMEOUT_CYCLES) begin
			@(negedge CLK);
			n++;
		end
		cycles = n;
		if (!fetch) begin
			$display("Timeout at %0t: no fetch phase within %0d cycles", $time, TIMEOUT_CYCLES);
			errors++;
			finishRun();
		end
	endtask

	task automatic compareSignal(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		assert (got === expected) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	function automatic void predictResult(input word_t instr, output regIndex_t dest,
		output word_t result, output logic carry);
		mode_t       mode;
		regIndex_t   destIdx;
		word_t       a;
		word_t       b;
		logic [16:0] sum;
		mode    = instr[9:8];
		destIdx = (mode == MODE_ACC_U8 || mode == MODE_ACC_U8HI) ? REG_R0 : instr[7:4];
		a       = model[destIdx];
		case (mode)
			MODE_REG_REG: b = model[instr[3:0]];
			MODE_REG_U4:  b = {12'h000, instr[3:0]};
			MODE_ACC_U8:  b = {8'h00, instr[7:0]};
			default:      b = {instr[7:0], 8'h00};
		endcase
		carry = 1'b0;
		case (instr[13:10])
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_ADD: begin
				sum    = {1'b0, a} + {1'b0, b};
				result = sum[15:0];
				carry  = sum[16];
			end
			ALU_SUB: begin
				result = a - b;
				carry  = (a < b); // borrow
			end
			ALU_SHL: begin
				result = {a[14:0], 1'b0};
				carry  = a[15];
			end
			ALU_SHR: begin
				result = {1'b0, a[15:1]};
				carry  = a[0];
			end
			ALU_NOT: result = ~a;
			default: result = b; // mov and unused codes
		endcase
		dest = destIdx;
	endfunction

	// one instruction per round, checked in the next fetch
	task automatic runInstr(input word_t instr);
		regIndex_t dest;
		word_t     result;
		logic      carry;
		logic      isAlu;
		int        cycles;
		waitForFetch(cycles);
		instruction = instr;
		isAlu = (instr[15:14] == GROUP_ARITHMETIC_LOGIC);
		if (isAlu) begin
			predictResult(instr, dest, result, carry);
			model[dest] = result;
		end
		@(negedge CLK);
		waitForFetch(cycles);
		compareSignal("latency", 16'(cycles + 1), 16'd4);
		compareSignal("writeValid", 16'(writeValid), 16'(isAlu));
		if (isAlu) begin
			compareSignal("writeReg", 16'(writeReg), 16'(dest));
			compareSignal("writeData", writeData, result);
			compareSignal("zeroFlag", 16'(zeroFlag), 16'(result == 16'h0000));
			compareSignal("carryFlag", 16'(carryFlag), 16'(carry));
		end
	endtask

	function automatic word_t aluInstr(input aluOp_t op, input mode_t mode, input logic [7:0] arg);
		return {GROUP_ARITHMETIC_LOGIC, op, mode, arg};
	endfunction

	// r0 is the staging register, so load it last
	task automatic loadReg(input regIndex_t idx, input word_t value);
		runInstr(aluInstr(ALU_MOV, MODE_ACC_U8HI, value[15:8]));
		runInstr(aluInstr(ALU_OR, MODE_ACC_U8, value[7:0]));
		if (idx != REG_R0)
			runInstr(aluInstr(ALU_MOV, MODE_REG_REG, {idx, REG_R0}));
	endtask

	task automatic startTest();
		testErrors = errors;
		testsRun++;
	endtask

	task automatic endTest(input string name);
		if (errors > testErrors) begin
			testsFailed++;
			$display("test %0d %s: failed with %0d errors", testsRun, name, errors - testErrors);
		end else begin
			$display("test %0d %s: ok", testsRun, name);
		end
	endtask

	initial begin
		aluOp_t ops [10] = '{ALU_MOV, ALU_AND, ALU_OR, ALU_XOR, ALU_ADD,
			ALU_SUB, ALU_SHL, ALU_SHR, ALU_NOT, 4'hF};
		group_t others [3] = '{GROUP_GENERAL, GROUP_LOAD_STORE, GROUP_JUMP};
		logic [31:0] rnd;
		regIndex_t   target;
		int cycles;
		void'($urandom(60994));
		reset = 1'b1;
		instruction = '0;
		for (int i = 0; i < 16; i++)
			model[i] = '0;
		repeat (10) @(negedge CLK);
		reset = 1'b0;

		startTest();
		waitForFetch(cycles);
		compareSignal("writeValid", 16'(writeValid), 16'h0000);
		endTest("reset and first fetch");

		startTest();
		for (int i = 15; i >= 0; i--)
			loadReg(4'(i), 16'($urandom()));
		for (int i = 0; i < 10; i++)
			runInstr(aluInstr(ops[i], MODE_REG_REG, {4'(i + 1), 4'(15 - i)}));
		endTest("register-register operations");

		startTest();
		runInstr(aluInstr(ALU_ADD, MODE_REG_U4, 8'h3F));
		runInstr(aluInstr(ALU_MOV, MODE_REG_U4, 8'h57));
		runInstr(aluInstr(ALU_AND, MODE_REG_U4, 8'h9C));
		runInstr(aluInstr(ALU_MOV, MODE_ACC_U8HI, 8'hA5));
		runInstr(aluInstr(ALU_XOR, MODE_ACC_U8HI, 8'hFF));
		runInstr(aluInstr(ALU_ADD, MODE_ACC_U8, 8'h80));
		endTest("immediate operands");

		startTest();
		loadReg(4'd1, 16'hFFFF);
		loadReg(4'd2, 16'h0001);
		runInstr(aluInstr(ALU_ADD, MODE_REG_REG, 8'h12)); // wraps to zero with carry
		runInstr(aluInstr(ALU_SUB, MODE_REG_REG, 8'h12)); // 0 - 1 borrows
		loadReg(4'd3, 16'h1234);
		loadReg(4'd4, 16'h1234);
		runInstr(aluInstr(ALU_SUB, MODE_REG_REG, 8'h34)); // zero, no borrow
		runInstr(aluInstr(ALU_ADD, MODE_REG_U4, 8'h35));
		endTest("carry, borrow and zero flags");

		startTest();
		for (int i = 0; i < 3; i++) begin
			rnd = $urandom();
			runInstr({others[i], rnd[13:0]});
			// the register a stray write would have hit
			target = (rnd[9:8] == MODE_ACC_U8 || rnd[9:8] == MODE_ACC_U8HI) ? REG_R0 : rnd[7:4];
			runInstr(aluInstr(ALU_MOV, MODE_REG_REG, {target, target}));
		end
		endTest("non-ALU instructions");

		startTest();
		repeat (200) begin
			rnd = $urandom();
			runInstr({GROUP_ARITHMETIC_LOGIC, rnd[13:0]});
		end
		endTest("random ALU instructions");

		finishRun();
	end

endmodule

`default_nettype wire

/* sim/forthAluCore_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module forthAluCoreChk (
	input logic CLK,
	input logic reset,
	input logic fetch,
	input logic decode,
	input logic execute,
	input logic commit,
	input logic regAWen,
	input logic regAClkEn,
	input logic regBClkEn
);

	int failCount = 0; // read by the testbench at the end

	phaseOneHot: assert property (@(posedge CLK) disable iff (reset)
		$onehot({fetch, decode, execute, commit}))
		else begin
			$error("phase strobes are not one-hot");
			failCount++;
		end

	// fetch -> decode -> execute -> commit -> fetch
	phaseRotation: assert property (@(posedge CLK) disable iff (reset)
		1'b1 |=> ({decode, execute, commit, fetch} == $past({fetch, decode, execute, commit})))
		else begin
			$error("phase strobes did not rotate in order");
			failCount++;
		end

	writeInCommit: assert property (@(posedge CLK) disable iff (reset) regAWen |-> commit)
		else begin
			$error("register write enable outside commit");
			failCount++;
		end

	readInExecute: assert property (@(posedge CLK) disable iff (reset)
		(regAClkEn || regBClkEn) |-> execute)
		else begin
			$error("read clock enable outside execute");
			failCount++;
		end

endmodule

bind forthAluCore forthAluCoreChk chk_i (.*);

`default_nettype wire

/* source/forthAluCore.sv */
`timescale 1ns/1ps
`default_nettype none

module forthAluCore
	import forthIsaPkg::*;
	import forthCtrlPkg::*;
(
	input  logic      CLK,
	input  logic      reset,
	input  word_t     instruction,
	output logic      fetch,
	output logic      writeValid,
	output regIndex_t writeReg,
	output word_t     writeData,
	output logic      zeroFlag,
	output logic      carryFlag
);

	logic       decode;
	logic       execute;
	logic       commit;
	logic       regAClkEn;
	logic       regBClkEn;
	logic       regAWen;
	regIndex_t  regAIndex;
	regIndex_t  regBIndex;
	aluOp_t     aluOp;
	aSource_t   aSource;
	bSource_t   bSource;
	logic [7:0] immediate;
	word_t      readA;
	word_t      readB;
	word_t      aluWriteData; // combinational result during commit

	instructionPhaseDecoder phase_i (
		.CLK     (CLK),
		.reset   (reset),
		.fetch   (fetch),
		.decode  (decode),
		.execute (execute),
		.commit  (commit)
	);

	aluGroupDecoder decoder_i (
		.CLK         (CLK),
		.reset       (reset),
		.instruction (instruction),
		.fetch       (fetch),
		.decode      (decode),
		.execute     (execute),
		.commit      (commit),
		.regAClkEn   (regAClkEn),
		.regBClkEn   (regBClkEn),
		.regAWen     (regAWen),
		.regAIndex   (regAIndex),
		.regBIndex   (regBIndex),
		.aluOp       (aluOp),
		.aSource     (aSource),
		.bSource     (bSource),
		.immediate   (immediate)
	);

	registerFile regs_i (
		.CLK       (CLK),
		.reset     (reset),
		.regAIndex (regAIndex),
		.regBIndex (regBIndex),
		.regAClkEn (regAClkEn),
		.regBClkEn (regBClkEn),
		.regAWen   (regAWen),
		.writeData (aluWriteData),
		.readA     (readA),
		.readB     (readB)
	);

	aluDatapath alu_i (
		.CLK        (CLK),
		.reset      (reset),
		.commit     (commit),
		.readA      (readA),
		.readB      (readB),
		.aSource    (aSource),
		.bSource    (bSource),
		.aluOp      (aluOp),
		.immediate  (immediate),
		.writeData  (aluWriteData),
		.resultData (writeData),
		.zeroFlag   (zeroFlag),
		.carryFlag  (carryFlag)
	);

	// write-back report, valid for one cycle in the following fetch
	always_ff @(posedge CLK) begin
		if (reset) begin
			writeValid <= 1'b0;
			writeReg   <= '0;
		end else begin
			writeValid <= regAWen; // only ever high during commit
			if (commit)
				writeReg <= regAIndex;
		end
	end

endmodule

`default_nettype wire

/* source/aluDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module aluDatapath
	import forthIsaPkg::*;
	import forthCtrlPkg::*;
(
	input  logic       CLK,
	input  logic       reset,
	input  logic       commit,
	input  word_t      readA,
	input  word_t      readB,
	input  aSource_t   aSource,
	input  bSource_t   bSource,
	input  aluOp_t     aluOp,
	input  logic [7:0] immediate,
	output word_t      writeData,
	output word_t      resultData,
	output logic       zeroFlag,
	output logic       carryFlag
);

	word_t       operandA;
	word_t       operandB;
	logic [16:0] aluResult; // bit 16 is carry or borrow

	assign operandA = readA; // accumulator modes address port A to r0

	always_comb begin
		case (bSource)
			ALU_B_SOURCEX_ARG_U4: operandB = {12'h000, immediate[3:0]};
			ALU_B_SOURCEX_ARG_U8: operandB = {8'h00, immediate};
			ALU_B_SOURCEX_U8_HI:  operandB = {immediate, 8'h00};
			default:              operandB = readB;
		endcase
	end

	always_comb begin
		case (aluOp)
			ALU_AND: aluResult = {1'b0, operandA & operandB};
			ALU_OR:  aluResult = {1'b0, operandA | operandB};
			ALU_XOR: aluResult = {1'b0, operandA ^ operandB};
			ALU_ADD: aluResult = {1'b0, operandA} + {1'b0, operandB};
			ALU_SUB: aluResult = {1'b0, operandA} - {1'b0, operandB}; // borrow when A < B
			ALU_SHL: aluResult = {operandA, 1'b0};
			ALU_SHR: aluResult = {operandA[0], 1'b0, operandA[15:1]}; // lsb falls into carry
			ALU_NOT: aluResult = {1'b0, ~operandA};
			default: aluResult = {1'b0, operandB}; // mov and unused codes
		endcase
	end

	assign writeData = aluResult[15:0];

	always_ff @(posedge CLK) begin
		if (reset) begin
			resultData <= '0;
			zeroFlag   <= 1'b0;
			carryFlag  <= 1'b0;
		end else if (commit) begin
			resultData <= writeData;
			zeroFlag   <= (writeData == '0);
			carryFlag  <= aluResult[16];
		end
	end

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import forthIsaPkg::*;
(
	input  logic      CLK,
	input  logic      reset,
	input  regIndex_t regAIndex,
	input  regIndex_t regBIndex,
	input  logic      regAClkEn,
	input  logic      regBClkEn,
	input  logic      regAWen,
	input  word_t     writeData,
	output word_t     readA,
	output word_t     readB
);

	word_t regs [16];

	// single write port, destination is always the A register
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (regAWen) begin
			regs[regAIndex] <= writeData;
		end
	end

	// registered read ports, loaded at the end of execute
	always_ff @(posedge CLK) begin
		if (regAClkEn)
			readA <= regs[regAIndex];
		if (regBClkEn)
			readB <= regs[regBIndex];
	end

endmodule

`default_nettype wire

/* source/aluGroupDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aluGroupDecoder
	import forthIsaPkg::*;
	import forthCtrlPkg::*;
(
	input  logic       CLK,
	input  logic       reset,
	input  word_t      instruction,
	input  logic       fetch,
	input  logic       decode,
	input  logic       execute,
	input  logic       commit,
	output logic       regAClkEn,
	output logic       regBClkEn,
	output logic       regAWen,
	output regIndex_t  regAIndex,
	output regIndex_t  regBIndex,
	output aluOp_t     aluOp,
	output aSource_t   aSource,
	output bSource_t   bSource,
	output logic [7:0] immediate
);

	word_t instrReg;    // held from the end of fetch to the next fetch
	logic  isAluGroup;  // set at the end of decode
	mode_t mode;
	logic  accMode;

	always_ff @(posedge CLK) begin
		if (reset) begin
			instrReg   <= '0;
			isAluGroup <= 1'b0;
		end else begin
			if (fetch)
				instrReg <= instruction;
			if (decode)
				isAluGroup <= (instrGroup(instrReg) == GROUP_ARITHMETIC_LOGIC);
		end
	end

	assign mode    = instrMode(instrReg);
	assign accMode = (mode == MODE_ACC_U8) || (mode == MODE_ACC_U8HI);

	// operand reads in execute, write back in commit
	assign regAClkEn = execute && isAluGroup;
	assign regBClkEn = execute && isAluGroup && (mode == MODE_REG_REG);
	assign regAWen   = commit && isAluGroup;

	// accumulator modes read and write r0, bits 7..4 then belong to the immediate
	assign regAIndex = accMode ? REG_R0 : instrRegA(instrReg);
	assign regBIndex = instrRegB(instrReg);

	assign aluOp     = instrAluOp(instrReg);
	assign immediate = instrReg[7:0];

	always_comb begin
		case (mode)
			MODE_REG_REG: begin
				aSource = ALU_A_SOURCEX_REG_A;
				bSource = ALU_B_SOURCEX_REG_B;
			end
			MODE_REG_U4: begin
				aSource = ALU_A_SOURCEX_REG_A;
				bSource = ALU_B_SOURCEX_ARG_U4;
			end
			MODE_ACC_U8: begin
				aSource = ALU_A_SOURCEX_R0;
				bSource = ALU_B_SOURCEX_ARG_U8;
			end
			default: begin // MODE_ACC_U8HI
				aSource = ALU_A_SOURCEX_R0;
				bSource = ALU_B_SOURCEX_U8_HI;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/instructionPhaseDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instructionPhaseDecoder
	import forthCtrlPkg::*;
(
	input  logic CLK,
	input  logic reset,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	phase_t phase;

	// free running rotation, no stalls
	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= PHASE_FETCH;
		end else begin
			case (phase)
				PHASE_FETCH:   phase <= PHASE_DECODE;
				PHASE_DECODE:  phase <= PHASE_EXECUTE;
				PHASE_EXECUTE: phase <= PHASE_COMMIT;
				PHASE_COMMIT:  phase <= PHASE_FETCH;
				default:       phase <= PHASE_FETCH;
			endcase
		end
	end

	assign fetch   = (phase == PHASE_FETCH);
	assign decode  = (phase == PHASE_DECODE);
	assign execute = (phase == PHASE_EXECUTE);
	assign commit  = (phase == PHASE_COMMIT);

endmodule

`default_nettype wire

/* source/forthCtrlPkg.sv */
`default_nettype none

package forthCtrlPkg;

	// one phase per cycle, four cycles per instruction
	typedef enum logic [1:0] {
		PHASE_FETCH   = 2'd0,
		PHASE_DECODE  = 2'd1,
		PHASE_EXECUTE = 2'd2,
		PHASE_COMMIT  = 2'd3
	} phase_t;

	typedef logic       aSource_t;
	typedef logic [1:0] bSource_t;

	localparam aSource_t ALU_A_SOURCEX_REG_A = 1'b0;
	localparam aSource_t ALU_A_SOURCEX_R0    = 1'b1;

	localparam bSource_t ALU_B_SOURCEX_REG_B  = 2'b00;
	localparam bSource_t ALU_B_SOURCEX_ARG_U4 = 2'b01; // zero-extended low nibble
	localparam bSource_t ALU_B_SOURCEX_ARG_U8 = 2'b10; // zero-extended low byte
	localparam bSource_t ALU_B_SOURCEX_U8_HI  = 2'b11; // low byte moved to the upper byte

endpackage

`default_nettype wire

/* source/forthIsaPkg.sv */
`default_nettype none

package forthIsaPkg;

	typedef logic [15:0] word_t;     // data word and instruction
	typedef logic [3:0]  regIndex_t;
	typedef logic [1:0]  group_t;
	typedef logic [3:0]  aluOp_t;
	typedef logic [1:0]  mode_t;

	// instruction group, bits 15..14
	localparam group_t GROUP_GENERAL          = 2'b00;
	localparam group_t GROUP_ARITHMETIC_LOGIC = 2'b01;
	localparam group_t GROUP_LOAD_STORE       = 2'b10;
	localparam group_t GROUP_JUMP             = 2'b11;

	// alu operation, bits 13..10
	localparam aluOp_t ALU_MOV = 4'h0;
	localparam aluOp_t ALU_AND = 4'h1;
	localparam aluOp_t ALU_OR  = 4'h2;
	localparam aluOp_t ALU_XOR = 4'h3;
	localparam aluOp_t ALU_ADD = 4'h4;
	localparam aluOp_t ALU_SUB = 4'h5;
	localparam aluOp_t ALU_SHL = 4'h6;
	localparam aluOp_t ALU_SHR = 4'h7;
	localparam aluOp_t ALU_NOT = 4'h8;

	// addressing mode, bits 9..8; destination is always the A operand register
	localparam mode_t MODE_REG_REG  = 2'b00;
	localparam mode_t MODE_REG_U4   = 2'b01;
	localparam mode_t MODE_ACC_U8   = 2'b10;
	localparam mode_t MODE_ACC_U8HI = 2'b11;

	localparam regIndex_t REG_R0 = 4'd0; // accumulator

	function automatic group_t instrGroup(input word_t instr);
		return instr[15:14];
	endfunction

	function automatic aluOp_t instrAluOp(input word_t instr);
		return instr[13:10];
	endfunction

	function automatic mode_t instrMode(input word_t instr);
		return instr[9:8];
	endfunction

	function automatic regIndex_t instrRegA(input word_t instr);
		return instr[7:4];
	endfunction

	function automatic regIndex_t instrRegB(input word_t instr);
		return instr[3:0];
	endfunction

endpackage

`default_nettype wire
